//--- dv/pong_tb.sv
/* Pong testbench
   frame table stimulus, raster timing checks and per-pixel compare
   against a frame-step model of the paddles and the ball */
`timescale 1ns/1ps

module pong_tb
    import pong_pkg::*;
();

    localparam int N_ROWS    = 11;
    localparam int PRESS_CYC = 64;                            // ctrl button hold time
    localparam int FRAME_CYC = H_TOTAL * V_TOTAL;
    localparam int P2_COL    = H_RES - P_OFFSET - P_WIDTH;    // mirrored paddle column
    localparam int P_LOW     = V_RES - P_HEIGHT - P_SPEED;    // no move down from here

    logic   clk_pix;
    logic   rst_n;
    logic   btn_up;
    logic   btn_dn;
    logic   btn_ctrl;
    logic   hsync;
    logic   vsync;
    logic   de;
    color_t r;
    color_t g;
    color_t b;

    // frame table, one row per scanned frame
    logic        row_up    [N_ROWS];
    logic        row_dn    [N_ROWS];
    logic        row_press [N_ROWS];
    game_state_t row_state [N_ROWS];  // state expected once the press is released

    int   m_bx;  // model positions shown in the current frame
    int   m_by;
    int   m_p1y;
    int   m_p2y;
    logic m_dx;  // 1 moves left
    logic m_dy;  // 1 moves up
    logic m_p2_col;   // model ball touched paddle 2 in the last frame
    logic turn_seen;  // DUT ball moved left after that contact
    int   seen_bx;    // leftmost ball column seen outside the paddle columns
    int   prev_bx;

    int timing_errs;
    int pixel_errs;
    int pos_errs;

    pong_top u_dut (
        .clk_pix  (clk_pix),
        .rst_n    (rst_n),
        .btn_up   (btn_up),
        .btn_dn   (btn_dn),
        .btn_ctrl (btn_ctrl),
        .hsync    (hsync),
        .vsync    (vsync),
        .de       (de),
        .r        (r),
        .g        (g),
        .b        (b)
    );

    always #5 clk_pix = ~clk_pix;

    task automatic set_row(input int k, input logic up, input logic dn, input logic press,
                           input game_state_t state);
        row_up[k]    = up;
        row_dn[k]    = dn;
        row_press[k] = press;
        row_state[k] = state;
    endtask

    function automatic logic inside_box(input int x, input int y, input int x0, input int y0,
                                        input int w, input int h);
        return (x >= x0) && (x < x0 + w) && (y >= y0) && (y < y0 + h);
    endfunction

    function automatic logic boxes_overlap(input int ax, input int ay, input int aw,
                                           input int ah, input int cx, input int cy,
                                           input int cw, input int ch);
        return (ax < cx + cw) && (cx < ax + aw) && (ay < cy + ch) && (cy < ay + ah);
    endfunction

    // paddle centre chases the ball rows
    function automatic int track_ball(input int py, input int ball_y);
        int centre;
        centre = py + P_HEIGHT / 2;
        if ((centre < ball_y) && (py < P_LOW)) return py + P_SPEED;
        if ((centre > ball_y + B_SIZE) && (py > P_SPEED)) return py - P_SPEED;
        return py;
    endfunction

    task automatic print_counts();
        $display("errors: timing %0d, pixel %0d, position %0d",
                 timing_errs, pixel_errs, pos_errs);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        print_counts();
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic timing_err(input string what, input int col, input int line);
        timing_errs++;
        $display("ERR %0t: %s wrong at column %0d line %0d", $time, what, col, line);
    endtask

    task automatic pixel_err(input string what, input int col, input int line);
        pixel_errs++;
        $display("ERR %0t: %s at column %0d line %0d", $time, what, col, line);
    endtask

    // model update at the frame pulse with the button levels of row k
    task automatic step_model(input int k);
        logic p1_col;
        logic p2_col;
        p1_col = boxes_overlap(m_bx, m_by, B_SIZE, B_SIZE, P_OFFSET, m_p1y, P_WIDTH, P_HEIGHT);
        p2_col = boxes_overlap(m_bx, m_by, B_SIZE, B_SIZE, P2_COL, m_p2y, P_WIDTH, P_HEIGHT);
        m_p2_col = p2_col;
        if (row_state[k] == PLAY) begin
            if (row_dn[k] && (m_p1y < P_LOW)) m_p1y = m_p1y + P_SPEED;
            else if (row_up[k] && (m_p1y > P_SPEED)) m_p1y = m_p1y - P_SPEED;
        end else begin
            m_p1y = track_ball(m_p1y, m_by);
        end
        m_p2y = track_ball(m_p2y, m_by);  // uses the old ball row
        if (p1_col) m_dx = 1'b0;
        else if (p2_col) m_dx = 1'b1;
        else if (m_bx >= H_RES - B_SPX - B_SIZE) m_dx = 1'b1;
        else if (m_bx < B_SPX) m_dx = 1'b0;
        if (m_by >= V_RES - B_SPY - B_SIZE) m_dy = 1'b1;
        else if (m_by < B_SPY) m_dy = 1'b0;
        m_bx = m_dx ? m_bx - B_SPX : m_bx + B_SPX;
        m_by = m_dy ? m_by - B_SPY : m_by + B_SPY;
    endtask

    task automatic wait_first_pixel();
        int n;
        n = 0;
        @(negedge clk_pix);
        while (!de) begin
            if (n >= FRAME_CYC) abort_run("no active video seen after reset");
            @(negedge clk_pix);
            n++;
        end
    endtask

    // starts on the first pixel of a frame, ends on the first pixel of the next
    task automatic scan_frame(input int k);
        int   t;
        int   col;
        int   line;
        int   mism;
        int   p1_top;
        int   p2_top;
        int   ball_x;
        int   ball_y;
        logic vs_seen;
        logic lit;
        logic exp_lit;
        t       = 0;
        mism    = 0;
        p1_top  = V_RES;
        p2_top  = V_RES;
        ball_x  = H_RES;
        ball_y  = V_RES;
        vs_seen = 1'b0;
        while (!(vs_seen && de)) begin
            if (t >= 2 * FRAME_CYC) abort_run("timeout waiting for the end of vsync");
            col  = t % H_TOTAL;
            line = t / H_TOTAL;
            if (de !== ((col < H_RES) && (line < V_RES))) timing_err("de", col, line);
            if (hsync !== !((col >= H_RES + H_FP) && (col < H_RES + H_FP + H_SYNC)))
                timing_err("hsync", col, line);
            if (vsync !== !((line >= V_RES + V_FP) && (line < V_RES + V_FP + V_SYNC)))
                timing_err("vsync", col, line);
            if (!vsync) vs_seen = 1'b1;
            lit = (r != 4'h0) || (g != 4'h0) || (b != 4'h0);
            if (!de && lit) pixel_err("rgb not black in blanking", col, line);
            if (lit && !((r == 4'hf) && (g == 4'hf) && (b == 4'hf)))
                pixel_err("lit pixel not white", col, line);
            if (de) begin
                exp_lit = inside_box(col, line, m_bx, m_by, B_SIZE, B_SIZE)
                       || inside_box(col, line, P_OFFSET, m_p1y, P_WIDTH, P_HEIGHT)
                       || inside_box(col, line, P2_COL, m_p2y, P_WIDTH, P_HEIGHT);
                if (lit !== exp_lit) mism++;
                if (lit && (col >= P_OFFSET) && (col < P_OFFSET + P_WIDTH)) begin
                    if (line < p1_top) p1_top = line;
                end else if (lit && (col >= P2_COL) && (col < P2_COL + P_WIDTH)) begin
                    if (line < p2_top) p2_top = line;
                end else if (lit) begin
                    if (col < ball_x) ball_x = col;
                    if (line < ball_y) ball_y = line;
                end
            end
            @(posedge clk_pix);
            if (t == 0) begin
                btn_up   <= row_up[k];
                btn_dn   <= row_dn[k];
                btn_ctrl <= row_press[k];
            end else if (t == PRESS_CYC) begin
                btn_ctrl <= 1'b0;  // release toggles the state
            end
            @(negedge clk_pix);
            t++;
        end
        seen_bx = ball_x;
        if (t != FRAME_CYC) begin
            timing_errs++;
            $display("ERR %0t: frame %0d lasted %0d cycles, expected %0d", $time, k, t, FRAME_CYC);
        end
        if (mism != 0) begin
            pos_errs++;
            $display("ERR %0t: frame %0d has %0d wrong pixels, ball (%0d,%0d) p1 %0d p2 %0d",
                     $time, k, mism, m_bx, m_by, m_p1y, m_p2y);
            $display("    seen ball (%0d,%0d) p1 %0d p2 %0d", ball_x, ball_y, p1_top, p2_top);
        end
    endtask

    initial begin
        int k;
        clk_pix     = 1'b0;
        rst_n       = 1'b0;
        btn_up      = 1'b0;
        btn_dn      = 1'b0;
        btn_ctrl    = 1'b0;
        timing_errs = 0;
        pixel_errs  = 0;
        pos_errs    = 0;
        set_row(0,  1'b0, 1'b0, 1'b0, IDLE);
        set_row(1,  1'b0, 1'b0, 1'b0, IDLE);
        set_row(2,  1'b0, 1'b0, 1'b0, IDLE);  // ball meets paddle 2 here
        set_row(3,  1'b0, 1'b0, 1'b0, IDLE);
        set_row(4,  1'b0, 1'b0, 1'b1, PLAY);
        set_row(5,  1'b1, 1'b0, 1'b0, PLAY);
        set_row(6,  1'b1, 1'b0, 1'b0, PLAY);
        set_row(7,  1'b0, 1'b1, 1'b0, PLAY);
        set_row(8,  1'b0, 1'b1, 1'b0, PLAY);
        set_row(9,  1'b0, 1'b0, 1'b1, IDLE);
        set_row(10, 1'b0, 1'b0, 1'b0, IDLE);
        m_bx      = B_RESET_X;
        m_by      = B_RESET_Y;
        m_p1y     = P_RESET_Y;
        m_p2y     = P_RESET_Y;
        m_dx      = 1'b0;
        m_dy      = 1'b0;
        m_p2_col  = 1'b0;
        turn_seen = 1'b0;
        seen_bx   = H_RES;
        prev_bx   = H_RES;
        repeat (2) @(posedge clk_pix);
        rst_n <= 1'b1;
        wait_first_pixel();
        for (k = 0; k < N_ROWS; k++) begin
            scan_frame(k);
            if (m_p2_col && (seen_bx < prev_bx)) turn_seen = 1'b1;
            prev_bx = seen_bx;
            step_model(k);
        end
        if (!turn_seen) begin
            pos_errs++;
            $display("the ball did not turn left after touching paddle 2");
        end
        print_counts();
        if (timing_errs + pixel_errs + pos_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- pong_top.f
verilog/pong_pkg.sv
verilog/game_if.sv
verilog/display_timings.sv
verilog/debounce.sv
verilog/paddle_ctrl.sv
verilog/ball_motion.sv
verilog/sprite_draw.sv
verilog/pong_top.sv
dv/pong_tb.sv

//--- verilog/ball_motion.sv
/* Ball motion
   paddle collision latches, direction bounce and per-frame ball step */
`timescale 1ns/1ps

module ball_motion
    import pong_pkg::*;
(
    input  logic clk_pix,
    input  logic rst_n,
    input  logic frame,
    input  logic b_hit,   // ball pixel drawn
    input  logic p1_hit,  // ball over paddle 1
    input  logic p2_hit,  // ball over paddle 2
    game_if.ball gi
);

    localparam coord_t SPX = coord_t'(B_SPX);
    localparam coord_t SPY = coord_t'(B_SPY);

    logic p1_col;   // paddle 1 touched this frame
    logic p2_col;
    logic dx;       // 1 moves left
    logic dy;       // 1 moves up
    logic dx_next;
    logic dy_next;

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            p1_col <= 1'b0;
            p2_col <= 1'b0;
        end else if (frame) begin
            p1_col <= 1'b0;
            p2_col <= 1'b0;
        end else if (b_hit) begin
            if (p1_hit) p1_col <= 1'b1;
            if (p2_hit) p2_col <= 1'b1;
        end
    end

    always_comb begin
        if (p1_col) begin
            dx_next = 1'b0;
        end else if (p2_col) begin
            dx_next = 1'b1;
        end else if (gi.bx >= coord_t'(H_RES - B_SPX - B_SIZE)) begin
            dx_next = 1'b1;  // right edge
        end else if (gi.bx < SPX) begin
            dx_next = 1'b0;  // left edge
        end else begin
            dx_next = dx;
        end

        if (gi.by >= coord_t'(V_RES - B_SPY - B_SIZE)) begin
            dy_next = 1'b1;  // bottom edge
        end else if (gi.by < SPY) begin
            dy_next = 1'b0;  // top edge
        end else begin
            dy_next = dy;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            gi.bx <= coord_t'(B_RESET_X);
            gi.by <= coord_t'(B_RESET_Y);
            dx    <= 1'b0;  // right and down
            dy    <= 1'b0;
        end else if (frame) begin
            dx    <= dx_next;
            dy    <= dy_next;
            gi.bx <= dx_next ? gi.bx - SPX : gi.bx + SPX;
            gi.by <= dy_next ? gi.by - SPY : gi.by + SPY;
        end
    end

endmodule

//--- verilog/debounce.sv
/* Button debouncer
   two-flop synchronizer and stability counter, level out plus release pulse */
`timescale 1ns/1ps

module debounce
    import pong_pkg::*;
(
    input  logic clk_pix,
    input  logic rst_n,
    input  logic in,     // raw button
    output logic level,  // debounced level
    output logic rel     // one cycle on a falling level
);

    logic [1:0]        sync_q;
    logic              last;    // last synchronized sample
    logic [DEB_CW-1:0] cnt;

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            sync_q <= '0;
            last   <= 1'b0;
            cnt    <= '0;
            level  <= 1'b0;
            rel    <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], in};
            rel    <= 1'b0;
            if (sync_q[1] != last) begin
                last <= sync_q[1];
                cnt  <= DEB_CW'(DEB_LEN - 1);  // restart on any change
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end else if (level != last) begin
                level <= last;
                rel   <= level;  // was high, now released
            end
        end
    end

endmodule

//--- verilog/display_timings.sv
/* Display timing generator
   pixel and line counters for the 640x480 raster with sync, data enable
   and a one-cycle pulse at the start of vertical blanking */
`timescale 1ns/1ps

module display_timings
    import pong_pkg::*;
(
    input  logic   clk_pix,
    input  logic   rst_n,
    output coord_t sx,      // current column
    output coord_t sy,      // current line
    output logic   hsync,
    output logic   vsync,
    output logic   de,
    output logic   frame
);

    logic line_end;
    logic frame_end;

    assign line_end  = (sx == coord_t'(H_TOTAL - 1));
    assign frame_end = (sy == coord_t'(V_TOTAL - 1));

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (line_end) begin
            sx <= '0;
            sy <= frame_end ? '0 : sy + 1'b1;
        end else begin
            sx <= sx + 1'b1;
        end
    end

    always_comb begin
        // both syncs are active low
        hsync = !((sx >= coord_t'(HS_STA)) && (sx <= coord_t'(HS_END)));
        vsync = !((sy >= coord_t'(VS_STA)) && (sy <= coord_t'(VS_END)));
        de    = (sx < coord_t'(H_RES)) && (sy < coord_t'(V_RES));

        // first blanking line, first column
        frame = (sy == coord_t'(V_RES)) && (sx == '0);
    end

endmodule

//--- verilog/game_if.sv
/* Game object positions
   paddle rows and ball position shared by game logic and drawing */
`timescale 1ns/1ps

interface game_if
    import pong_pkg::*;
();

    coord_t p1y;  // top row of paddle 1
    coord_t p2y;  // top row of paddle 2
    coord_t bx;   // ball left column
    coord_t by;   // ball top row

    modport pad (
        output p1y, p2y,
        input  by
    );

    modport ball (
        output bx, by
    );

    modport draw (
        input p1y, p2y, bx, by
    );

endinterface

//--- verilog/paddle_ctrl.sv
/* Paddle control
   IDLE/PLAY state and per-frame update of both paddles */
`timescale 1ns/1ps

module paddle_ctrl
    import pong_pkg::*;
(
    input  logic clk_pix,
    input  logic rst_n,
    input  logic frame,
    input  logic move_up,
    input  logic move_dn,
    input  logic ctrl_rel,
    game_if.pad  gi
);

    localparam coord_t SPD  = coord_t'(P_SPEED);
    localparam coord_t YMAX = coord_t'(P_Y_MAX);

    game_state_t state;
    coord_t      p1_next;
    coord_t      p2_next;

    // move the paddle centre towards the ball, within the screen limits
    function automatic coord_t track(input coord_t py, input coord_t ball_y);
        coord_t centre;
        coord_t ty;
        centre = py + coord_t'(P_HEIGHT / 2);
        ty     = py;
        if ((centre < ball_y) && (py < YMAX)) begin
            ty = py + SPD;  // ball top is below
        end
        if ((centre > ball_y + coord_t'(B_SIZE)) && (py > SPD)) begin
            ty = py - SPD;  // ball bottom is above
        end
        return ty;
    endfunction

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            state <= IDLE;
        end else if (ctrl_rel) begin
            state <= (state == IDLE) ? PLAY : IDLE;
        end
    end

    always_comb begin
        if (state == PLAY) begin
            p1_next = gi.p1y;
            if (move_up && (gi.p1y > SPD)) begin
                p1_next = gi.p1y - SPD;
            end
            if (move_dn && (gi.p1y < YMAX)) begin
                p1_next = gi.p1y + SPD;  // down wins if both held
            end
        end else begin
            p1_next = track(gi.p1y, gi.by);
        end
        p2_next = track(gi.p2y, gi.by);
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            gi.p1y <= coord_t'(P_RESET_Y);
            gi.p2y <= coord_t'(P_RESET_Y);
        end else if (frame) begin
            gi.p1y <= p1_next;
            gi.p2y <= p2_next;
        end
    end

endmodule

//--- verilog/pong_pkg.sv
/* Pong shared definitions
   raster timing, sprite geometry, debounce length and common types */
package pong_pkg;

    typedef logic [9:0] coord_t;  // screen coordinate
    typedef logic [3:0] color_t;  // one colour channel
    typedef enum logic {IDLE = 1'b0, PLAY = 1'b1} game_state_t;

    // 640x480 at 60 Hz, negative sync
    localparam int H_RES   = 640;
    localparam int V_RES   = 480;
    localparam int H_FP    = 16;
    localparam int H_SYNC  = 96;
    localparam int H_BP    = 48;
    localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;  // 800
    localparam int V_FP    = 10;
    localparam int V_SYNC  = 2;
    localparam int V_BP    = 33;
    localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;  // 525
    localparam int HS_STA  = H_RES + H_FP;                  // 656
    localparam int HS_END  = HS_STA + H_SYNC - 1;           // 751
    localparam int VS_STA  = V_RES + V_FP;                  // 490
    localparam int VS_END  = VS_STA + V_SYNC - 1;           // 491

    localparam int P_HEIGHT  = 40;
    localparam int P_WIDTH   = 10;
    localparam int P_SPEED   = 4;
    localparam int P_OFFSET  = 32;   // from screen edge
    localparam int P_RESET_Y = 220;
    localparam int P_Y_MAX   = V_RES - P_HEIGHT - P_SPEED;  // lowest start of a move down
    localparam int P2_X      = H_RES - P_OFFSET - P_WIDTH;  // left column of paddle 2

    localparam int B_SIZE    = 8;
    localparam int B_SPX     = 6;
    localparam int B_SPY     = 4;
    localparam int B_RESET_X = 580;  // close to paddle 2
    localparam int B_RESET_Y = 200;

    localparam int DEB_LEN = 16;                   // stable cycles before a level change
    localparam int DEB_CW  = $clog2(DEB_LEN + 1);  // debounce counter width

endpackage

//--- verilog/pong_top.sv
/* Pong top level
   display timing, button debouncers, game logic and sprite drawing */
`timescale 1ns/1ps

module pong_top
    import pong_pkg::*;
(
    input  logic   clk_pix,
    input  logic   rst_n,
    input  logic   btn_up,
    input  logic   btn_dn,
    input  logic   btn_ctrl,
    output logic   hsync,
    output logic   vsync,
    output logic   de,
    output color_t r,
    output color_t g,
    output color_t b
);

    coord_t sx;
    coord_t sy;
    logic   frame;
    logic   move_up;
    logic   move_dn;
    logic   ctrl_rel;
    logic   b_hit;
    logic   p1_hit;
    logic   p2_hit;

    display_timings u_timings (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .sx      (sx),
        .sy      (sy),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .frame   (frame)
    );

    debounce u_deb_up   (.clk_pix(clk_pix), .rst_n(rst_n), .in(btn_up),   .level(move_up), .rel());
    debounce u_deb_dn   (.clk_pix(clk_pix), .rst_n(rst_n), .in(btn_dn),   .level(move_dn), .rel());
    debounce u_deb_ctrl (.clk_pix(clk_pix), .rst_n(rst_n), .in(btn_ctrl), .level(),
                         .rel(ctrl_rel));  // state toggles on release

    game_if u_gi ();

    paddle_ctrl u_paddles (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .frame   (frame),
        .move_up (move_up),
        .move_dn (move_dn),
        .ctrl_rel(ctrl_rel),
        .gi      (u_gi.pad)
    );

    ball_motion u_ball (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .frame   (frame),
        .b_hit   (b_hit),
        .p1_hit  (p1_hit),
        .p2_hit  (p2_hit),
        .gi      (u_gi.ball)
    );

    sprite_draw u_draw (
        .sx      (sx),
        .sy      (sy),
        .de      (de),
        .gi      (u_gi.draw),
        .b_hit   (b_hit),
        .p1_hit  (p1_hit),
        .p2_hit  (p2_hit),
        .r       (r),
        .g       (g),
        .b       (b)
    );

endmodule

//--- verilog/sprite_draw.sv
/* Sprite drawing
   ball and paddle hit tests on the current pixel, white on black RGB */
`timescale 1ns/1ps

module sprite_draw
    import pong_pkg::*;
(
    input  coord_t sx,
    input  coord_t sy,
    input  logic   de,
    game_if.draw   gi,
    output logic   b_hit,
    output logic   p1_hit,
    output logic   p2_hit,
    output color_t r,
    output color_t g,
    output color_t b
);

    logic b_draw;
    logic p1_draw;
    logic p2_draw;
    logic lit;

    always_comb begin
        b_draw  = (sx >= gi.bx) && (sx < gi.bx + coord_t'(B_SIZE))
               && (sy >= gi.by) && (sy < gi.by + coord_t'(B_SIZE));
        p1_draw = (sx >= coord_t'(P_OFFSET)) && (sx < coord_t'(P_OFFSET + P_WIDTH))
               && (sy >= gi.p1y) && (sy < gi.p1y + coord_t'(P_HEIGHT));
        // mirror of paddle 1 about the screen centre
        p2_draw = (sx >= coord_t'(P2_X)) && (sx < coord_t'(P2_X + P_WIDTH))
               && (sy >= gi.p2y) && (sy < gi.p2y + coord_t'(P_HEIGHT));
    end

    always_comb begin
        b_hit  = b_draw;
        p1_hit = b_draw && p1_draw;  // ball over paddle
        p2_hit = b_draw && p2_draw;
    end

    always_comb begin
        lit = de && (b_draw || p1_draw || p2_draw);
        r   = lit ? '1 : '0;
        g   = lit ? '1 : '0;
        b   = lit ? '1 : '0;
    end

endmodule
